// File: rtl/csr_isa_pkg.sv
`default_nettype none

package csr_isa_pkg;

   // Machine-mode CSR addresses
   localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
   localparam logic [11:0] ADDR_MIE      = 12'h304;
   localparam logic [11:0] ADDR_MTVEC    = 12'h305;
   localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
   localparam logic [11:0] ADDR_MEPC     = 12'h341;
   localparam logic [11:0] ADDR_MCAUSE   = 12'h342;

   typedef enum logic [2:0] {
      OP_CSRRW = 3'd0,
      OP_CSRRS = 3'd1,
      OP_CSRRC = 3'd2,
      OP_CSRR  = 3'd3,
      OP_TRAP  = 3'd4,
      OP_MRET  = 3'd5
   } csr_op_e;

   // New bit source during a serial access
   typedef enum logic [1:0] {
      SRC_CSR = 2'd0,  // Keep old bit
      SRC_EXT = 2'd1,
      SRC_SET = 2'd2,
      SRC_CLR = 2'd3
   } csr_src_e;

   typedef struct packed {
      logic irq;           // Interrupt, not exception
      logic e_op;          // ecall or ebreak
      logic ebreak;
      logic mem_misalign;
      logic mem_cmd;       // Store when set
   } trap_cause_t;

endpackage

`default_nettype wire

// File: rtl/csr_uarch_pkg.sv
`default_nettype none

package csr_uarch_pkg;

   localparam int CSR_W = 32;  // CSR word length
   localparam int CNT_W = 5;   // Serial bit counter

   // Strobes decoded from the bit counter
   typedef struct packed {
      logic cnt0to3;   // Bits 0 to 3
      logic cnt2;
      logic cnt3;
      logic cnt7;
      logic cnt_done;  // Bit 31
      logic en;        // Serial access active
   } bit_cnt_t;

   // One-hot register selects for the current access
   typedef struct packed {
      logic mstatus_en;
      logic mie_en;
      logic mcause_en;
      logic mscratch_en;
      logic mepc_en;
      logic mtvec_en;
   } csr_sel_t;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_SHIFT = 2'd1,
      ST_DONE  = 2'd2
   } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/csr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_ctrl (
   input  wire                            i_clk,
   input  wire                            i_rst_n,
   input  wire                            i_start,
   input  wire csr_isa_pkg::csr_op_e      i_op,
   input  wire [11:0]                     i_addr,
   input  wire csr_isa_pkg::trap_cause_t  i_cause,
   output csr_uarch_pkg::bit_cnt_t        o_cnt,
   output csr_uarch_pkg::csr_sel_t        o_sel,
   output csr_isa_pkg::csr_src_e          o_src,
   output logic                           o_trap_taken,
   output logic                           o_mret,
   output csr_isa_pkg::trap_cause_t       o_cause,
   output logic                           o_busy,
   output logic                           o_done
);
   import csr_isa_pkg::*;
   import csr_uarch_pkg::*;

   ctrl_state_e      state;
   logic [CNT_W-1:0] cnt;
   logic             shift_en;
   csr_sel_t         sel_dec;
   csr_src_e         src_dec;

   always_comb begin
      sel_dec = '0;
      case (i_addr)
         ADDR_MSTATUS:  sel_dec.mstatus_en  = 1'b1;
         ADDR_MIE:      sel_dec.mie_en      = 1'b1;
         ADDR_MCAUSE:   sel_dec.mcause_en   = 1'b1;
         ADDR_MSCRATCH: sel_dec.mscratch_en = 1'b1;
         ADDR_MEPC:     sel_dec.mepc_en     = 1'b1;
         ADDR_MTVEC:    sel_dec.mtvec_en    = 1'b1;
         default:       sel_dec = '0;  // Unknown address touches nothing
      endcase
   end

   always_comb begin
      case (i_op)
         OP_CSRRW: src_dec = SRC_EXT;
         OP_CSRRS: src_dec = SRC_SET;
         OP_CSRRC: src_dec = SRC_CLR;
         default:  src_dec = SRC_CSR;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state        <= ST_IDLE;
         cnt          <= '0;
         o_sel        <= '0;
         o_src        <= SRC_CSR;
         o_trap_taken <= 1'b0;
         o_mret       <= 1'b0;
         o_cause      <= '0;
      end else begin
         o_trap_taken <= 1'b0;  // Strobes last one cycle
         o_mret       <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  case (i_op)
                     OP_TRAP: begin
                        o_trap_taken <= 1'b1;
                        o_cause      <= i_cause;
                        state        <= ST_DONE;
                     end
                     OP_MRET: begin
                        o_mret <= 1'b1;
                        state  <= ST_DONE;
                     end
                     default: begin
                        o_sel <= sel_dec;
                        o_src <= src_dec;
                        cnt   <= '0;
                        state <= ST_SHIFT;
                     end
                  endcase
               end
            end
            ST_SHIFT: begin
               cnt <= cnt + CNT_W'(1);
               if (&cnt) begin  // Bit 31 ends the access
                  o_sel <= '0;
                  state <= ST_DONE;
               end
            end
            ST_DONE: state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign shift_en = (state == ST_SHIFT);

   always_comb begin
      o_cnt.en       = shift_en;
      o_cnt.cnt0to3  = shift_en && (cnt[CNT_W-1:2] == '0);
      o_cnt.cnt2     = shift_en && (cnt == CNT_W'(2));
      o_cnt.cnt3     = shift_en && (cnt == CNT_W'(3));
      o_cnt.cnt7     = shift_en && (cnt == CNT_W'(7));
      o_cnt.cnt_done = shift_en && (&cnt);
   end

   assign o_busy = (state != ST_IDLE);
   assign o_done = (state == ST_DONE);

endmodule

`default_nettype wire

// File: rtl/csr_status.sv
`timescale 1ns/1ps
`default_nettype none

module csr_status (
   input  wire                            i_clk,
   input  wire                            i_rst_n,
   input  wire csr_uarch_pkg::bit_cnt_t   i_cnt,
   input  wire csr_uarch_pkg::csr_sel_t   i_sel,
   input  wire csr_isa_pkg::csr_src_e     i_src,
   input  wire                            i_d,
   input  wire                            i_rf_out,
   input  wire                            i_trap_taken,
   input  wire                            i_mret,
   input  wire csr_isa_pkg::trap_cause_t  i_cause,
   input  wire                            i_mtip,
   output logic                           o_csr_in,
   output logic                           o_q,
   output logic                           o_new_irq
);
   import csr_isa_pkg::*;

   logic       mstatus_mie;
   logic       mstatus_mpie;   // Stored but not readable
   logic       mie_mtie;       // Write only
   logic       mcause31;
   logic [3:0] mcause3_0;
   logic       mstatus_rd;
   logic       mcause_bit;
   logic       csr_out;
   logic       timer_irq;
   logic       timer_irq_r;
   logic [3:0] trap_code;

   // MIE staged at bit 2 so it appears at bit 3
   assign mcause_bit = i_cnt.cnt0to3  ? mcause3_0[0] :
                       i_cnt.cnt_done ? mcause31 : 1'b0;

   assign csr_out = (i_sel.mstatus_en & i_cnt.en & mstatus_rd) |
                    (i_sel.mcause_en & i_cnt.en & mcause_bit) |
                    i_rf_out;

   always_comb begin
      case (i_src)
         SRC_EXT: o_csr_in = i_d;
         SRC_SET: o_csr_in = csr_out | i_d;
         SRC_CLR: o_csr_in = csr_out & ~i_d;
         default: o_csr_in = csr_out;
      endcase
   end

   always_comb begin
      if (i_cause.irq)
         trap_code = 4'd7;
      else if (i_cause.e_op)
         trap_code = i_cause.ebreak ? 4'd3 : 4'd11;
      else if (i_cause.mem_misalign)
         trap_code = i_cause.mem_cmd ? 4'd6 : 4'd4;
      else
         trap_code = 4'd0;
   end

   assign o_q       = csr_out;
   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;
   assign o_new_irq = timer_irq & ~timer_irq_r;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie     <= 1'b0;
         mcause31     <= 1'b0;
         mcause3_0    <= 4'd0;
         mstatus_rd   <= 1'b0;
         timer_irq_r  <= 1'b0;
      end else begin
         mstatus_rd  <= i_cnt.cnt2 & mstatus_mie;
         timer_irq_r <= timer_irq;
         if (i_sel.mstatus_en && i_cnt.cnt3)
            mstatus_mie <= o_csr_in;
         if (i_sel.mstatus_en && i_cnt.cnt7)
            mstatus_mpie <= o_csr_in;
         if (i_sel.mie_en && i_cnt.cnt7)
            mie_mtie <= o_csr_in;
         if (i_sel.mcause_en && i_cnt.cnt0to3)
            mcause3_0 <= {o_csr_in, mcause3_0[3:1]};  // Rotates through bit 0
         if (i_sel.mcause_en && i_cnt.cnt_done)
            mcause31 <= o_csr_in;
         if (i_mret)
            mstatus_mie <= mstatus_mpie;
         if (i_trap_taken) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mcause31     <= i_cause.irq;
            mcause3_0    <= trap_code;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/csr_scratch_rf.sv
`timescale 1ns/1ps
`default_nettype none

module csr_scratch_rf (
   input  wire                            i_clk,
   input  wire csr_uarch_pkg::bit_cnt_t   i_cnt,
   input  wire csr_uarch_pkg::csr_sel_t   i_sel,
   input  wire                            i_csr_in,
   output logic                           o_rf_out
);
   import csr_uarch_pkg::*;

   logic [CSR_W-1:0] rf [0:2];  // mscratch, mepc, mtvec
   logic [2:0]       rf_sel;

   assign rf_sel = {i_sel.mtvec_en, i_sel.mepc_en, i_sel.mscratch_en};

   // Each selected word rotates right, new bit entering at the top
   always_ff @(posedge i_clk) begin
      for (int i = 0; i < $size(rf); i++) begin
         if (i_cnt.en && rf_sel[i])
            rf[i] <= {i_csr_in, rf[i][CSR_W-1:1]};
      end
   end

   always_comb begin
      o_rf_out = 1'b0;
      for (int i = 0; i < $size(rf); i++) begin
         o_rf_out = o_rf_out | (rf_sel[i] & rf[i][0]);
      end
      o_rf_out = o_rf_out & i_cnt.en;
   end

endmodule

`default_nettype wire

// File: rtl/csr_serdes.sv
`timescale 1ns/1ps
`default_nettype none

module csr_serdes (
   input  wire                               i_clk,
   input  wire                               i_rst_n,
   input  wire                               i_start,
   input  wire                               i_busy,
   input  wire [csr_uarch_pkg::CSR_W-1:0]    i_wdata,
   input  wire csr_uarch_pkg::bit_cnt_t      i_cnt,
   input  wire                               i_q,
   output logic                              o_d,
   output logic [csr_uarch_pkg::CSR_W-1:0]   o_rdata
);
   import csr_uarch_pkg::*;

   logic [CSR_W-1:0] wdata_sr;
   logic [CSR_W-2:0] rdata_sr;  // Bits 0 to 30, bit 31 joins at capture

   always_ff @(posedge i_clk) begin
      if (i_start && !i_busy)
         wdata_sr <= i_wdata;
      else if (i_cnt.en)
         wdata_sr <= {1'b0, wdata_sr[CSR_W-1:1]};
      if (i_cnt.en)
         rdata_sr <= {i_q, rdata_sr[CSR_W-2:1]};
   end

   // Held until the next access completes
   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         o_rdata <= '0;
      else if (i_cnt.cnt_done)
         o_rdata <= {i_q, rdata_sr};
   end

   assign o_d = wdata_sr[0];

endmodule

`default_nettype wire

// File: rtl/csr_serial_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_serial_top (
   input  wire                               i_clk,
   input  wire                               i_rst_n,
   input  wire                               i_start,
   input  wire csr_isa_pkg::csr_op_e         i_op,
   input  wire [11:0]                        i_addr,
   input  wire [csr_uarch_pkg::CSR_W-1:0]    i_wdata,
   input  wire csr_isa_pkg::trap_cause_t     i_cause,
   input  wire                               i_mtip,
   output logic                              o_busy,
   output logic                              o_done,
   output logic [csr_uarch_pkg::CSR_W-1:0]   o_rdata,
   output logic                              o_new_irq
);
   import csr_isa_pkg::*;
   import csr_uarch_pkg::*;

   bit_cnt_t    cnt;
   csr_sel_t    sel;
   csr_src_e    csr_src;
   trap_cause_t cause;
   logic        trap_taken;
   logic        mret;
   logic        d;
   logic        q;
   logic        csr_in;
   logic        rf_out;

   csr_ctrl csr_ctrl_inst (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_start      (i_start),
      .i_op         (i_op),
      .i_addr       (i_addr),
      .i_cause      (i_cause),
      .o_cnt        (cnt),
      .o_sel        (sel),
      .o_src        (csr_src),
      .o_trap_taken (trap_taken),
      .o_mret       (mret),
      .o_cause      (cause),
      .o_busy       (o_busy),
      .o_done       (o_done)
   );

   csr_serdes csr_serdes_inst (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_start (i_start),
      .i_busy  (o_busy),
      .i_wdata (i_wdata),
      .i_cnt   (cnt),
      .i_q     (q),
      .o_d     (d),
      .o_rdata (o_rdata)
   );

   csr_status csr_status_inst (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_cnt        (cnt),
      .i_sel        (sel),
      .i_src        (csr_src),
      .i_d          (d),
      .i_rf_out     (rf_out),
      .i_trap_taken (trap_taken),
      .i_mret       (mret),
      .i_cause      (cause),
      .i_mtip       (i_mtip),
      .o_csr_in     (csr_in),
      .o_q          (q),
      .o_new_irq    (o_new_irq)
   );

   csr_scratch_rf csr_scratch_rf_inst (
      .i_clk    (i_clk),
      .i_cnt    (cnt),
      .i_sel    (sel),
      .i_csr_in (csr_in),
      .o_rf_out (rf_out)
   );

endmodule

`default_nettype wire

// File: test/csr_serial_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module csr_serial_asserts (
   input wire                           i_clk,
   input wire                           i_rst_n,
   input wire                           i_start,
   input wire csr_isa_pkg::csr_op_e     i_op,
   input wire                           i_busy,
   input wire                           i_done,
   input wire csr_uarch_pkg::csr_sel_t  i_sel
);
   import csr_isa_pkg::*;

   logic access_start;
   int   fail_cnt = 0;  // Failed assertion count

   // Serial accesses only, traps and mret finish in one cycle
   assign access_start = i_start && !i_busy && (i_op != OP_TRAP) && (i_op != OP_MRET);

   done_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_done |=> !i_done)
      else begin
         $error("o_done high in two consecutive cycles");
         fail_cnt++;
      end

   done_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      access_start |-> ##33 i_done)
      else begin
         $error("o_done missing 33 cycles after an accepted access");
         fail_cnt++;
      end

   sel_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0(i_sel))
      else begin
         $error("o_sel is neither one-hot nor zero");
         fail_cnt++;
      end

endmodule

bind csr_ctrl csr_serial_asserts csr_serial_asserts_inst (
   .i_clk   (i_clk),
   .i_rst_n (i_rst_n),
   .i_start (i_start),
   .i_op    (i_op),
   .i_busy  (o_busy),
   .i_done  (o_done),
   .i_sel   (o_sel)
);

`default_nettype wire

// File: test/csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_checker (
   input wire                            i_clk,
   input wire                            i_rst_n,
   input wire                            i_start,
   input wire csr_isa_pkg::csr_op_e      i_op,
   input wire [11:0]                     i_addr,
   input wire [31:0]                     i_wdata,
   input wire csr_isa_pkg::trap_cause_t  i_cause,
   input wire                            i_mtip,
   input wire                            i_busy,
   input wire                            i_done,
   input wire [31:0]                     i_rdata,
   input wire                            i_new_irq
);
   import csr_isa_pkg::*;

   typedef struct packed {
      logic             mie;
      logic             mpie;
      logic             mtie;
      logic             mcause31;
      logic [3:0]       mcause_lo;
      logic [2:0]       rf_known;  // Scratch words start undefined
      logic [2:0][31:0] rf;
   } model_t;

   typedef struct packed {
      csr_op_e     op;
      logic [11:0] addr;
      logic [31:0] wdata;
      trap_cause_t cause;
   } cmd_t;

   model_t      model;
   cmd_t        cmd;
   int          remain = 0;  // Cycles until the expected o_done
   logic        irq_prev;
   logic        irq_cond;
   logic [31:0] last_rdata;
   logic        last_known;
   int          test_errors = 0;
   int          pass_count = 0;
   int          fail_count = 0;

   function automatic model_t step_model(input model_t m, input cmd_t c,
                                         output logic [31:0] old_val, output logic old_known);
      model_t      n;
      logic [31:0] nv;
      int          idx;
      n = m;
      old_val = '0;
      old_known = 1'b1;
      idx = -1;
      case (c.addr)
         ADDR_MSTATUS:  old_val[3] = m.mie;
         ADDR_MCAUSE:   old_val = {m.mcause31, 27'd0, m.mcause_lo};
         ADDR_MSCRATCH: idx = 0;
         ADDR_MEPC:     idx = 1;
         ADDR_MTVEC:    idx = 2;
         default:       old_val = '0;  // mie reads as zero
      endcase
      if (idx >= 0) begin
         old_val = m.rf[idx];
         old_known = m.rf_known[idx];
      end
      case (c.op)
         OP_CSRRW: nv = c.wdata;
         OP_CSRRS: nv = old_val | c.wdata;
         OP_CSRRC: nv = old_val & ~c.wdata;
         default:  nv = old_val;
      endcase
      if (c.op == OP_TRAP) begin
         n.mpie = m.mie;
         n.mie = 1'b0;
         n.mcause31 = c.cause.irq;
         if (c.cause.irq)
            n.mcause_lo = 4'd7;
         else if (c.cause.e_op)
            n.mcause_lo = c.cause.ebreak ? 4'd3 : 4'd11;
         else if (c.cause.mem_misalign)
            n.mcause_lo = c.cause.mem_cmd ? 4'd6 : 4'd4;
         else
            n.mcause_lo = 4'd0;
      end else if (c.op == OP_MRET) begin
         n.mie = m.mpie;
      end else begin
         case (c.addr)
            ADDR_MSTATUS: {n.mpie, n.mie} = {nv[7], nv[3]};
            ADDR_MIE:     n.mtie = nv[7];
            ADDR_MCAUSE:  {n.mcause31, n.mcause_lo} = {nv[31], nv[3:0]};
            default:      n.mtie = m.mtie;
         endcase
         if (idx >= 0) begin
            n.rf[idx] = nv;
            n.rf_known[idx] = m.rf_known[idx] | (c.op == OP_CSRRW);
         end
      end
      return n;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("[ERROR] t=%0t %s expected %08h got %08h", $time, name, exp, act);
         test_errors++;
      end
   endtask

   task automatic report_problem(input string msg);
      $display("t=%0t %s", $time, msg);
      test_errors++;
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         pass_count++;
         $display("test %s passed", name);
      end else begin
         fail_count++;
         $display("test %s failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic complete_cmd();
      logic [31:0] old_val;
      logic        old_known;
      model_t      next;
      next = step_model(model, cmd, old_val, old_known);
      if (cmd.op == OP_TRAP || cmd.op == OP_MRET) begin
         if (last_known)
            check_val("o_rdata", last_rdata, i_rdata);  // Held from last access
      end else begin
         if (old_known)
            check_val("o_rdata", old_val, i_rdata);
         last_rdata = old_val;
         last_known = old_known;
      end
      model = next;
   endtask

   // Sampled on the falling edge, away from input and state updates
   always @(negedge i_clk) begin
      if (!i_rst_n) begin
         model = '0;
         remain = 0;
         irq_prev = 1'b0;
         last_rdata = '0;
         last_known = 1'b1;
      end else begin
         irq_cond = i_mtip & model.mie & model.mtie;
         check_val("o_new_irq", {31'd0, irq_cond & ~irq_prev}, {31'd0, i_new_irq});
         irq_prev = irq_cond;
         check_val("o_busy", {31'd0, remain != 0}, {31'd0, i_busy});
         check_val("o_done", {31'd0, remain == 1}, {31'd0, i_done});
         if (remain != 0) begin
            if (remain == 1)
               complete_cmd();
            remain--;
         end else if (i_start) begin
            cmd.op = i_op;
            cmd.addr = i_addr;
            cmd.wdata = i_wdata;
            cmd.cause = i_cause;
            remain = (i_op == OP_TRAP || i_op == OP_MRET) ? 1 : 33;
         end
      end
   end

endmodule

`default_nettype wire

// File: test/tb_csr_serial.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_serial;
   import csr_isa_pkg::*;

   localparam int N_CMDS = 64;  // Includes stray starts and mtip windows
   localparam int MAX_CYCLES = N_CMDS * 40 + 100;

   logic        i_clk;
   logic        i_rst_n;
   logic        i_start;
   csr_op_e     i_op;
   logic [11:0] i_addr;
   logic [31:0] i_wdata;
   trap_cause_t i_cause;
   logic        i_mtip;
   logic        o_busy;
   logic        o_done;
   logic [31:0] o_rdata;
   logic        o_new_irq;
   integer      seed = 32'ha262d523;
   int          cycle_cnt = 0;

   csr_serial_top csr_serial_top_inst (.*);

   csr_checker csr_checker_inst (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_start   (i_start),
      .i_op      (i_op),
      .i_addr    (i_addr),
      .i_wdata   (i_wdata),
      .i_cause   (i_cause),
      .i_mtip    (i_mtip),
      .i_busy    (o_busy),
      .i_done    (o_done),
      .i_rdata   (o_rdata),
      .i_new_irq (o_new_irq)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   task automatic wait_done();
      int waited;
      waited = 0;
      do begin
         @(negedge i_clk);
         waited++;
      end while (!o_done && waited < 40);
      if (!o_done)
         csr_checker_inst.report_problem("o_done did not arrive within 40 cycles");
   endtask

   // A second command that must be ignored
   task automatic set_stray(input logic [31:0] wdata);
      i_start <= 1'b1;
      i_op    <= OP_CSRRW;
      i_addr  <= ADDR_MSCRATCH;
      i_wdata <= ~wdata;
   endtask

   task automatic run_cmd(input csr_op_e op, input logic [11:0] addr, input logic [31:0] wdata,
                          input trap_cause_t cause, input int stray_at);
      @(posedge i_clk);
      i_start <= 1'b1;
      i_op    <= op;
      i_addr  <= addr;
      i_wdata <= wdata;
      i_cause <= cause;
      @(posedge i_clk);
      if (stray_at == 1)
         set_stray(wdata);
      else
         i_start <= 1'b0;
      fork
         wait_done();
         begin
            if (stray_at > 1) begin
               repeat (stray_at - 1) @(posedge i_clk);
               set_stray(wdata);
            end
            if (stray_at > 0) begin
               @(posedge i_clk);
               i_start <= 1'b0;
            end
         end
      join
   endtask

   task automatic csr_access(input csr_op_e op, input logic [11:0] addr, input logic [31:0] wdata);
      run_cmd(op, addr, wdata, '0, 0);
   endtask

   task automatic event_cmd(input csr_op_e op, input trap_cause_t cause);
      run_cmd(op, 12'h000, 32'h0, cause, 0);
   endtask

   task automatic pulse_mtip();
      @(posedge i_clk);
      i_mtip <= 1'b1;
      repeat (6) @(posedge i_clk);
      i_mtip <= 1'b0;
      repeat (2) @(posedge i_clk);
   endtask

   task automatic end_test(input string name);
      repeat (2) @(posedge i_clk);
      csr_checker_inst.finish_test(name);
   endtask

   initial begin : watchdog
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin : stimulus
      logic [11:0] rf_addr [3];
      trap_cause_t causes [6];
      rf_addr = '{ADDR_MSCRATCH, ADDR_MEPC, ADDR_MTVEC};
      // irq, ecall, ebreak, load misalign, store misalign, none
      causes = '{5'b10000, 5'b01000, 5'b01100, 5'b00010, 5'b00011, 5'b00000};
      i_rst_n = 1'b0;
      i_start = 1'b0;
      i_op    = OP_CSRR;
      i_addr  = '0;
      i_wdata = '0;
      i_cause = '0;
      i_mtip  = 1'b0;
      repeat (3) @(posedge i_clk);
      i_rst_n <= 1'b1;

      for (int i = 0; i < 3; i++) begin
         csr_access(OP_CSRRW, rf_addr[i], $random(seed));  // Old value still undefined
         csr_access(OP_CSRRW, rf_addr[i], $random(seed));
         csr_access(OP_CSRR, rf_addr[i], 32'h0);
      end
      end_test("scratch_rw");

      csr_access(OP_CSRRW, ADDR_MSCRATCH, $random(seed));
      csr_access(OP_CSRRS, ADDR_MSCRATCH, $random(seed));
      csr_access(OP_CSRR, ADDR_MSCRATCH, 32'h0);
      csr_access(OP_CSRRC, ADDR_MSCRATCH, $random(seed));
      csr_access(OP_CSRR, ADDR_MSCRATCH, 32'h0);
      end_test("scratch_set_clear");

      csr_access(OP_CSRRW, ADDR_MSTATUS, 32'hffff_ffff);
      csr_access(OP_CSRR, ADDR_MSTATUS, 32'h0);
      csr_access(OP_CSRRW, ADDR_MCAUSE, 32'hffff_ffff);
      csr_access(OP_CSRR, ADDR_MCAUSE, 32'h0);
      csr_access(OP_CSRRC, ADDR_MCAUSE, 32'hffff_ffff);
      csr_access(OP_CSRR, ADDR_MCAUSE, 32'h0);
      csr_access(OP_CSRRW, ADDR_MIE, 32'hffff_ffff);
      csr_access(OP_CSRR, ADDR_MIE, 32'h0);
      end_test("field_masks");

      csr_access(OP_CSRRS, ADDR_MSTATUS, 32'h8);
      for (int i = 0; i < 6; i++) begin
         event_cmd(OP_TRAP, causes[i]);
         csr_access(OP_CSRR, ADDR_MCAUSE, 32'h0);
         event_cmd(OP_MRET, '0);
         csr_access(OP_CSRR, ADDR_MSTATUS, 32'h0);
      end
      event_cmd(OP_TRAP, causes[0]);
      csr_access(OP_CSRR, ADDR_MSTATUS, 32'h0);  // Also clears MPIE
      event_cmd(OP_MRET, '0);
      csr_access(OP_CSRR, ADDR_MSTATUS, 32'h0);
      end_test("trap_mret");

      csr_access(OP_CSRRW, ADDR_MSTATUS, 32'h0);
      csr_access(OP_CSRRW, ADDR_MIE, 32'h80);
      pulse_mtip();
      csr_access(OP_CSRRW, ADDR_MSTATUS, 32'h8);
      pulse_mtip();
      csr_access(OP_CSRRW, ADDR_MIE, 32'h0);
      pulse_mtip();
      end_test("timer_irq");

      run_cmd(OP_CSRRW, ADDR_MSCRATCH, $random(seed), '0, 5);
      csr_access(OP_CSRR, ADDR_MSCRATCH, 32'h0);
      run_cmd(OP_TRAP, 12'h000, 32'h0, causes[1], 1);  // Start held into the done cycle
      event_cmd(OP_MRET, '0);
      csr_access(OP_CSRR, ADDR_MSCRATCH, 32'h0);
      end_test("busy_start");

      repeat (2) @(posedge i_clk);
      $display("tests passed: %0d, tests failed: %0d",
               csr_checker_inst.pass_count, csr_checker_inst.fail_count);
      if (csr_checker_inst.fail_count == 0 && csr_checker_inst.test_errors == 0 &&
          csr_serial_top_inst.csr_ctrl_inst.csr_serial_asserts_inst.fail_cnt == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: csr_serial.f
rtl/csr_isa_pkg.sv
rtl/csr_uarch_pkg.sv
rtl/csr_ctrl.sv
rtl/csr_status.sv
rtl/csr_scratch_rf.sv
rtl/csr_serdes.sv
rtl/csr_serial_top.sv
test/csr_serial_asserts.sv
test/csr_checker.sv
test/tb_csr_serial.sv
